// File: Makefile
VERILATOR = verilator
FLAGS = --timing
TOP = tb_cpu_top
FILELIST = cpu_top.f
OBJ = obj_dir
LOG = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ)

sim: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/cpu_testdata.txt
# P word_addr instr_word (hex)
# E pc rf_we rf_waddr rf_wdata dm_we dm_addr dm_wdata (hex), one per commit in order
P 00 34018001  ori  $1,$0,0x8001
P 01 3c021234  lui  $2,0x1234
P 02 00221821  addu $3,$1,$2
P 03 34050001  ori  $5,$0,0x0001
P 04 00052023  subu $4,$0,$5
P 05 00853021  addu $6,$4,$5
P 06 34005555  ori  $0,$0,0x5555
P 07 00013821  addu $7,$0,$1
P 08 34080100  ori  $8,$0,0x0100
P 09 ad03fff8  sw   $3,-8($8)
P 0a 8d09fff8  lw   $9,-8($8)
P 0b 10250001  beq  $1,$5,+1 (not taken)
P 0c 10690002  beq  $3,$9,+2 (taken to 0x3c)
P 0d 340adead  ori  $10,$0,0xdead (skipped)
P 0e 340bbeef  ori  $11,$0,0xbeef (skipped)
P 0f fc00ffff  undefined opcode
P 10 00221820  add, funct not supported
P 11 00000000  nop
P 12 01276021  addu $12,$9,$7
P 13 1000ffff  beq  $0,$0,-1 (loop)
E 00000000 1 01 00008001 0 00000000 00000000
E 00000004 1 02 12340000 0 00000000 00000000
E 00000008 1 03 12348001 0 00000000 00000000
E 0000000c 1 05 00000001 0 00000000 00000000
E 00000010 1 04 ffffffff 0 00000000 00000000
E 00000014 1 06 00000000 0 00000000 00000000
E 00000018 1 00 00005555 0 00000000 00000000
E 0000001c 1 07 00008001 0 00000000 00000000
E 00000020 1 08 00000100 0 00000000 00000000
E 00000024 0 00 00000000 1 000000f8 12348001
E 00000028 1 09 12348001 0 00000000 00000000
E 0000002c 0 00 00000000 0 00000000 00000000
E 00000030 0 00 00000000 0 00000000 00000000
E 0000003c 0 00 00000000 0 00000000 00000000
E 00000040 0 00 00000000 0 00000000 00000000
E 00000044 0 00 00000000 0 00000000 00000000
E 00000048 1 0c 12350002 0 00000000 00000000
E 0000004c 0 00 00000000 0 00000000 00000000
E 0000004c 0 00 00000000 0 00000000 00000000

// File: bench/tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_top;

	localparam int MAX_RECORDS = 64;
	localparam int RESET_CYCLES = 10;

	logic clk;
	logic rst;
	logic run;
	logic load_en;
	logic [`IM_ADDR_BITS-1:0] load_addr;
	logic [31:0] load_data;
	logic commit_valid;
	logic [31:0] commit_pc;
	logic [31:0] commit_instr;
	logic rf_we;
	logic [4:0] rf_waddr;
	logic [31:0] rf_wdata;
	logic dm_we;
	logic [31:0] dm_addr;
	logic [31:0] dm_wdata;

	logic [31:0] prog [0:(1<<`IM_ADDR_BITS)-1]; // Loaded words by word address
	logic [31:0] p_addr [0:MAX_RECORDS-1];
	logic [31:0] p_word [0:MAX_RECORDS-1];
	logic [31:0] e_pc [0:MAX_RECORDS-1];
	logic e_rf_we [0:MAX_RECORDS-1];
	logic [4:0] e_waddr [0:MAX_RECORDS-1];
	logic [31:0] e_wdata [0:MAX_RECORDS-1];
	logic e_dm_we [0:MAX_RECORDS-1];
	logic [31:0] e_daddr [0:MAX_RECORDS-1];
	logic [31:0] e_ddata [0:MAX_RECORDS-1];
	int p_count;
	int e_count;
	int errors;
	int checks;
	int cycles;
	int cycle_limit;

	cpu_top dut0 (
		.clk(clk),
		.rst(rst),
		.run(run),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.commit_valid(commit_valid),
		.commit_pc(commit_pc),
		.commit_instr(commit_instr),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.dm_we(dm_we),
		.dm_addr(dm_addr),
		.dm_wdata(dm_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("FAIL %s at pc %h: expected %h, got %h", name, commit_pc, exp, got);
		errors++;
	endtask

	// P and E records, # lines are comments
	task automatic parse_data_file();
		int fd;
		int n;
		byte c;
		string line;
		logic [31:0] v_pc;
		logic [31:0] v_rfwe;
		logic [31:0] v_waddr;
		logic [31:0] v_wdata;
		logic [31:0] v_dmwe;
		logic [31:0] v_daddr;
		logic [31:0] v_ddata;
		fd = $fopen("bench/cpu_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/cpu_testdata.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line.len() == 0)
				continue;
			c = line.getc(0);
			if (c == "P" && p_count < MAX_RECORDS) begin
				n = $sscanf(line, "P %h %h", v_pc, v_wdata);
				if (n != 2) begin
					$display("program record is incomplete: %s", line);
					errors++;
				end
				p_addr[p_count] = v_pc;
				p_word[p_count] = v_wdata;
				prog[v_pc[`IM_ADDR_BITS-1:0]] = v_wdata;
				p_count++;
			end else if (c == "E" && e_count < MAX_RECORDS) begin
				n = $sscanf(line, "E %h %h %h %h %h %h %h", v_pc, v_rfwe, v_waddr,
					v_wdata, v_dmwe, v_daddr, v_ddata);
				if (n != 7) begin
					$display("expected commit record is incomplete: %s", line);
					errors++;
				end
				e_pc[e_count] = v_pc;
				e_rf_we[e_count] = v_rfwe[0];
				e_waddr[e_count] = v_waddr[4:0];
				e_wdata[e_count] = v_wdata;
				e_dm_we[e_count] = v_dmwe[0];
				e_daddr[e_count] = v_daddr;
				e_ddata[e_count] = v_ddata;
				e_count++;
			end else if (c != "#" && c != "\n" && c != "\r" && c != " ") begin
				$display("data file line not understood: %s", line);
				errors++;
			end
		end
		$fclose(fd);
		if (e_count == 0) begin
			$display("data file holds no expected commits");
			errors++;
		end
	endtask

	task automatic expect_idle();
		checks++;
		if (commit_valid !== 1'b0)
			report_mismatch("commit_valid", 32'd0, {31'd0, commit_valid});
		if (rf_we !== 1'b0)
			report_mismatch("rf_we", 32'd0, {31'd0, rf_we});
		if (dm_we !== 1'b0)
			report_mismatch("dm_we", 32'd0, {31'd0, dm_we});
	endtask

	task automatic compare_commit(input int idx);
		checks++;
		if (commit_pc !== e_pc[idx])
			report_mismatch("commit_pc", e_pc[idx], commit_pc);
		if (commit_instr !== prog[e_pc[idx][`IM_ADDR_BITS+1:2]])
			report_mismatch("commit_instr", prog[e_pc[idx][`IM_ADDR_BITS+1:2]], commit_instr);
		if (rf_we !== e_rf_we[idx])
			report_mismatch("rf_we", {31'd0, e_rf_we[idx]}, {31'd0, rf_we});
		if (dm_we !== e_dm_we[idx])
			report_mismatch("dm_we", {31'd0, e_dm_we[idx]}, {31'd0, dm_we});
		if (e_rf_we[idx] && rf_waddr !== e_waddr[idx])
			report_mismatch("rf_waddr", {27'd0, e_waddr[idx]}, {27'd0, rf_waddr});
		if (e_rf_we[idx] && rf_wdata !== e_wdata[idx])
			report_mismatch("rf_wdata", e_wdata[idx], rf_wdata);
		if (e_dm_we[idx] && dm_addr !== e_daddr[idx])
			report_mismatch("dm_addr", e_daddr[idx], dm_addr);
		if (e_dm_we[idx] && dm_wdata !== e_ddata[idx])
			report_mismatch("dm_wdata", e_ddata[idx], dm_wdata);
	endtask

	// Run limit from the length of the test
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout before all commits were seen");
			$display("checks: %0d, errors: %0d", checks, errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		int e_idx;
		rst = 1'b1;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = 32'h0000_0000;
		errors = 0;
		checks = 0;
		cycles = 0;
		p_count = 0;
		e_count = 0;
		e_idx = 0;
		parse_data_file();
		cycle_limit = RESET_CYCLES + p_count + e_count + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < p_count; i++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= p_addr[i][`IM_ADDR_BITS-1:0];
			load_data <= p_word[i];
			@(negedge clk);
			expect_idle(); // Nothing commits while loading
		end
		@(posedge clk);
		load_en <= 1'b0;
		run <= 1'b1;
		while (e_idx < e_count) begin
			@(negedge clk);
			if (commit_valid === 1'b1) begin
				compare_commit(e_idx);
				e_idx++;
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: cpu_top.f
+incdir+include
source/isa_pkg.sv
source/ctrl_pkg.sv
source/ctrl_if.sv
source/fetch_unit.sv
source/control.sv
source/reg_file.sv
source/exec_unit.sv
source/data_mem.sv
source/cpu_top.sv
bench/tb_cpu_top.sv

// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Instruction memory depth is 2**IM_ADDR_BITS words
`define IM_ADDR_BITS 8

// Data memory depth is 2**DM_ADDR_BITS words
`define DM_ADDR_BITS 8

`define RESET_PC 32'h0000_0000

`endif

// File: source/control.sv
`timescale 1ns/1ps

module control (
	input isa_pkg::instr_t instr,
	ctrl_if.decoder ctl
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	instr_kind_t kind;

	always_comb begin
		kind = INSTR_UNKNOWN;
		if (instr == 32'h0000_0000) begin
			kind = INSTR_NOP;
		end else begin
			case (instr.r_fields.op)
				OP_RTYPE: begin
					if (instr.r_fields.funct == FUNCT_ADDU)
						kind = INSTR_ADDU;
					else if (instr.r_fields.funct == FUNCT_SUBU)
						kind = INSTR_SUBU;
				end
				OP_LUI: kind = INSTR_LUI;
				OP_ORI: kind = INSTR_ORI;
				OP_LW: kind = INSTR_LW;
				OP_SW: kind = INSTR_SW;
				OP_BEQ: kind = INSTR_BEQ;
				default: kind = INSTR_UNKNOWN;
			endcase
		end
	end

	always_comb begin
		// Safe defaults, also used for nop and unknown words
		ctl.alu_op = ALU_OR;
		ctl.ext_mode = EXT_UNSIGNED;
		ctl.alu_src_imm = 1'b0;
		ctl.npc_mode = NPC_SEQUENTIAL;
		ctl.rf_we = 1'b0;
		ctl.dm_we = 1'b0;
		ctl.wb_src = WB_ALU_RESULT;
		ctl.dst_sel = DST_RT;

		case (kind)
			INSTR_ADDU, INSTR_SUBU: begin
				ctl.alu_op = (kind == INSTR_ADDU) ? ALU_ADD : ALU_SUB;
				ctl.rf_we = 1'b1;
				ctl.dst_sel = DST_RD;
			end
			INSTR_LUI, INSTR_ORI: begin
				ctl.ext_mode = (kind == INSTR_LUI) ? EXT_PAD : EXT_UNSIGNED;
				ctl.alu_src_imm = 1'b1;
				ctl.rf_we = 1'b1; // lui ORs with $0
			end
			INSTR_LW: begin
				ctl.alu_op = ALU_ADD;
				ctl.ext_mode = EXT_SIGNED;
				ctl.alu_src_imm = 1'b1;
				ctl.rf_we = 1'b1;
				ctl.wb_src = WB_MEM_DATA;
			end
			INSTR_SW: begin
				ctl.alu_op = ALU_ADD;
				ctl.ext_mode = EXT_SIGNED;
				ctl.alu_src_imm = 1'b1;
				ctl.dm_we = 1'b1;
			end
			INSTR_BEQ: ctl.npc_mode = NPC_BRANCH_EQUAL;
			default: ;
		endcase
	end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
	input logic clk,
	input logic rst,
	input logic run,
	input logic load_en,
	input logic [`IM_ADDR_BITS-1:0] load_addr,
	input logic [31:0] load_data,
	output logic commit_valid,
	output logic [31:0] commit_pc,
	output logic [31:0] commit_instr,
	output logic rf_we,
	output logic [4:0] rf_waddr,
	output logic [31:0] rf_wdata,
	output logic dm_we,
	output logic [31:0] dm_addr,
	output logic [31:0] dm_wdata
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	ctrl_if ctl ();

	instr_t instr;
	logic [31:0] pc;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_result;
	logic [31:0] mem_rdata;
	logic rs_equal;

	fetch_unit #(.ADDR_BITS(`IM_ADDR_BITS)) fetch0 (
		.clk(clk),
		.rst(rst),
		.run(run),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.rs_equal(rs_equal),
		.ctl(ctl.fetch),
		.pc(pc),
		.instr(instr)
	);

	control ctrl0 (
		.instr(instr),
		.ctl(ctl.decoder)
	);

	reg_file rf0 (
		.clk(clk),
		.rst(rst),
		.ra1(instr.r_fields.rs),
		.ra2(instr.r_fields.rt),
		.we(rf_we),
		.wa(rf_waddr),
		.wd(rf_wdata),
		.rd1(rs_val),
		.rd2(rt_val)
	);

	exec_unit ex0 (
		.instr(instr),
		.rs_val(rs_val),
		.rt_val(rt_val),
		.ctl(ctl.exec),
		.result(alu_result),
		.rs_equal(rs_equal)
	);

	data_mem #(.ADDR_BITS(`DM_ADDR_BITS)) dm0 (
		.clk(clk),
		.we(dm_we),
		.addr(alu_result),
		.wdata(rt_val),
		.rdata(mem_rdata)
	);

	// Write-back path
	assign rf_waddr = (ctl.dst_sel == DST_RD) ? instr.r_fields.rd : instr.r_fields.rt;
	assign rf_wdata = (ctl.wb_src == WB_MEM_DATA) ? mem_rdata : alu_result;
	assign rf_we = run & ctl.rf_we; // No writes while stalled
	assign dm_we = run & ctl.dm_we;

	assign dm_addr = alu_result;
	assign dm_wdata = rt_val;

	assign commit_valid = run;
	assign commit_pc = pc;
	assign commit_instr = instr;

endmodule

// File: source/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;
	import ctrl_pkg::*;

	alu_op_t alu_op;
	ext_mode_t ext_mode;
	logic alu_src_imm; // Operand b from immediate
	npc_mode_t npc_mode;
	logic rf_we;
	logic dm_we;
	wb_src_t wb_src;
	dst_sel_t dst_sel;

	modport decoder (
		output alu_op, ext_mode, alu_src_imm, npc_mode,
		output rf_we, dm_we, wb_src, dst_sel
	);

	modport fetch (input npc_mode);

	modport exec (input alu_op, ext_mode, alu_src_imm);

	modport wb (input rf_we, dm_we, wb_src, dst_sel);

endinterface

// File: source/ctrl_pkg.sv
package ctrl_pkg;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR
	} alu_op_t;

	typedef enum logic [1:0] {
		EXT_UNSIGNED, // Zero extend
		EXT_SIGNED,
		EXT_PAD // Imm to upper half
	} ext_mode_t;

	typedef enum logic {
		NPC_SEQUENTIAL,
		NPC_BRANCH_EQUAL
	} npc_mode_t;

	typedef enum logic {
		WB_ALU_RESULT,
		WB_MEM_DATA
	} wb_src_t;

	typedef enum logic {
		DST_RD,
		DST_RT
	} dst_sel_t;

endpackage

// File: source/data_mem.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module data_mem #(
	parameter int ADDR_BITS = `DM_ADDR_BITS
) (
	input logic clk,
	input logic we,
	input logic [31:0] addr,
	input logic [31:0] wdata,
	output logic [31:0] rdata
);

	logic [31:0] mem [0:(1<<ADDR_BITS)-1];
	logic [ADDR_BITS-1:0] index;

	assign index = addr[ADDR_BITS+1:2]; // Word index, upper bits dropped

	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wdata;
		end
	end

	assign rdata = mem[index];

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input isa_pkg::instr_t instr,
	input logic [31:0] rs_val,
	input logic [31:0] rt_val,
	ctrl_if.exec ctl,
	output logic [31:0] result,
	output logic rs_equal
);
	import ctrl_pkg::*;

	logic [31:0] imm_ext;
	logic [31:0] operand_b;

	always_comb begin
		case (ctl.ext_mode)
			EXT_SIGNED: imm_ext = {{16{instr.i_fields.imm[15]}}, instr.i_fields.imm};
			EXT_PAD: imm_ext = {instr.i_fields.imm, 16'h0000};
			default: imm_ext = {16'h0000, instr.i_fields.imm};
		endcase
	end

	assign operand_b = ctl.alu_src_imm ? imm_ext : rt_val;

	always_comb begin
		case (ctl.alu_op)
			ALU_ADD: result = rs_val + operand_b; // Wraps, no trap
			ALU_SUB: result = rs_val - operand_b;
			default: result = rs_val | operand_b;
		endcase
	end

	// Branch compare on raw register values
	assign rs_equal = (rs_val == rt_val);

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_unit #(
	parameter int ADDR_BITS = `IM_ADDR_BITS
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic load_en,
	input logic [ADDR_BITS-1:0] load_addr,
	input logic [31:0] load_data,
	input logic rs_equal,
	ctrl_if.fetch ctl,
	output logic [31:0] pc,
	output isa_pkg::instr_t instr
);
	import ctrl_pkg::*;

	logic [31:0] imem [0:(1<<ADDR_BITS)-1];
	logic [31:0] pc_plus4;
	logic [31:0] branch_offset;
	logic [31:0] next_pc;
	logic take_branch;

	assign pc_plus4 = pc + 32'd4;

	// Word offset, sign extended
	assign branch_offset = {{14{instr.i_fields.imm[15]}}, instr.i_fields.imm, 2'b00};

	assign take_branch = (ctl.npc_mode == NPC_BRANCH_EQUAL) && rs_equal;
	assign next_pc = take_branch ? pc_plus4 + branch_offset : pc_plus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else if (run) begin
			pc <= next_pc; // Holds while run is low
		end
	end

	always_ff @(posedge clk) begin
		if (load_en) begin
			imem[load_addr] <= load_data;
		end
	end

	assign instr = imem[pc[ADDR_BITS+1:2]];

endmodule

// File: source/isa_pkg.sv
package isa_pkg;

	typedef logic [5:0] op_t;
	typedef logic [5:0] funct_t;

	localparam op_t OP_RTYPE = 6'h00;
	localparam op_t OP_LUI = 6'h0f;
	localparam op_t OP_ORI = 6'h0d;
	localparam op_t OP_LW = 6'h23;
	localparam op_t OP_SW = 6'h2b;
	localparam op_t OP_BEQ = 6'h04;

	localparam funct_t FUNCT_ADDU = 6'h21;
	localparam funct_t FUNCT_SUBU = 6'h23;

	typedef struct packed {
		op_t op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t funct;
	} r_fields_t;

	typedef struct packed {
		op_t op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_fields_t;

	// One word, two views of its low bits
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_t;

	typedef enum logic [3:0] {
		INSTR_ADDU,
		INSTR_SUBU,
		INSTR_LUI,
		INSTR_ORI,
		INSTR_LW,
		INSTR_SW,
		INSTR_BEQ,
		INSTR_NOP,
		INSTR_UNKNOWN
	} instr_kind_t;

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic we,
	input logic [4:0] wa,
	input logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'h0000_0000;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd; // $0 ignores writes
		end
	end

	assign rd1 = (ra1 == 5'd0) ? 32'h0000_0000 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'h0000_0000 : regs[ra2];

endmodule
